// ==== compile.f ====
hw/mdc_pkg.sv
hw/hamming_decoder.sv
hw/beat_counter.sv
hw/mdc_ctrl.sv
hw/matrix_store.sv
hw/det_unit.sv
hw/result_assembler.sv
hw/mdc_top.sv
testbench/tb_clock_gen.sv
testbench/mdc_checker.sv
testbench/tb_mdc.sv

// ==== hw/beat_counter.sv ====
// ============================================================
// input beat counter, index of the current element
// ============================================================
`timescale 1ns/100ps

module beat_counter
(
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      in_valid,
    output logic [mdc_pkg::beat_w-1:0] beat
);
    import mdc_pkg::*;

    // wraps to 0 after beat 15, cleared between matrices
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            beat <= '0;
        end
        else if (in_valid)
        begin
            beat <= beat + 1'b1;
        end
        else
        begin
            beat <= '0;
        end
    end

    // a matrix is exactly sixteen back-to-back beats
    a_burst_len: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(in_valid) |-> in_valid [*num_elems] ##1 !in_valid);

endmodule

// ==== hw/det_unit.sv ====
// ============================================================
// window scheduler and 2x2 / 3x3 determinant datapath
// ============================================================
`timescale 1ns/100ps

module det_unit
(
    input  mdc_pkg::mdc_state_e                                state,
    input  logic [mdc_pkg::beat_w-1:0]                         beat,
    input  logic [mdc_pkg::num_elems-1:0][mdc_pkg::elem_w-1:0] elems,
    input  mdc_pkg::mat_size_e                                 mat_size,
    output logic signed [mdc_pkg::slot3_w-1:0]                 det_value,
    output logic                                               slot_write,
    output logic [3:0]                                         slot_index
);
    import mdc_pkg::*;

    logic [beat_w:0]            eff_beat;
    logic [beat_w-1:0]          base;
    logic signed [elem_w-1:0]   m [3][3];
    logic signed [det2_w-1:0]   cof0;
    logic signed [det2_w-1:0]   cof1;
    logic signed [det2_w-1:0]   cof2;
    logic signed [det3_w-1:0]   det3;

    function automatic logic signed [det2_w-1:0] det2(
        input logic signed [elem_w-1:0] a,
        input logic signed [elem_w-1:0] b,
        input logic signed [elem_w-1:0] c,
        input logic signed [elem_w-1:0] d
    );
        logic signed [det2_w-1:0] ad;
        logic signed [det2_w-1:0] bc;
        ad = a * d;
        bc = b * c;
        return ad - bc;
    endfunction

    // ============================================================
    // schedule: a window fires once its last element is stored
    // ============================================================
    always_comb
    begin
        slot_write = 1'b0;
        slot_index = '0;
        if (state == WAIT)
        begin
            // windows that need element 15
            slot_write = 1'b1;
            slot_index = (mat_size == SIZE3) ? 4'd3 : 4'd8;
        end
        else if (state == CAL)
        begin
            slot_write = 1'b1;
            if (mat_size == SIZE2)
            begin
                case (beat)
                    4'd6:    slot_index = 4'd0;
                    4'd7:    slot_index = 4'd1;
                    4'd8:    slot_index = 4'd2;
                    4'd10:   slot_index = 4'd3;
                    4'd11:   slot_index = 4'd4;
                    4'd12:   slot_index = 4'd5;
                    4'd14:   slot_index = 4'd6;
                    4'd15:   slot_index = 4'd7;
                    default: slot_write = 1'b0;
                endcase
            end
            else
            begin
                case (beat)
                    4'd11:   slot_index = 4'd0;
                    4'd12:   slot_index = 4'd1;
                    4'd15:   slot_index = 4'd2;
                    default: slot_write = 1'b0;
                endcase
            end
        end
    end

    // ============================================================
    // window selection
    // ============================================================
    // last element of a window is base+5 or base+10, stored one beat
    // before the window fires; WAIT acts as beat 16
    assign eff_beat = (state == WAIT) ? (beat_w + 1)'(num_elems) : {1'b0, beat};
    assign base = (mat_size == SIZE3) ? beat_w'(eff_beat - 5'd11) : beat_w'(eff_beat - 5'd6);

    // index wraps mod 16, row 2 is unused in size 2
    always_comb
    begin
        for (int r = 0; r < 3; r++)
        begin
            for (int c = 0; c < 3; c++)
            begin
                m[r][c] = $signed(elems[beat_w'(base + 4 * r + c)]);
            end
        end
    end

    // cofactors along the bottom row, cof2 doubles as the size-2 result
    assign cof0 = det2(m[0][1], m[0][2], m[1][1], m[1][2]);
    assign cof1 = det2(m[0][0], m[0][2], m[1][0], m[1][2]);
    assign cof2 = det2(m[0][0], m[0][1], m[1][0], m[1][1]);
    assign det3 = cof0 * m[2][0] - cof1 * m[2][1] + cof2 * m[2][2];

    assign det_value = (mat_size == SIZE3) ?
                       {{(slot3_w - det3_w){det3[det3_w-1]}}, det3} :
                       {{(slot3_w - det2_w){cof2[det2_w-1]}}, cof2};

endmodule

// ==== hw/hamming_decoder.sv ====
// ============================================================
// single-error-correcting hamming decoder
// parity at positions 1, 2, 4, 8, data msb first
// ============================================================
`timescale 1ns/100ps

module hamming_decoder #(
    parameter int data_w = 11
)
(
    input  logic [data_w+3:0] code,
    output logic [data_w-1:0] data
);
    localparam int code_w = data_w + 4;

    logic [3:0]        syndrome;
    logic [code_w-1:0] corrected;

    // position p lives at bit code_w-p
    always_comb
    begin
        syndrome = '0;
        for (int p = 1; p <= code_w; p++)
        begin
            if (code[code_w - p])
            begin
                syndrome = syndrome ^ 4'(p);
            end
        end
    end

    // flip the bit the syndrome points at, zero syndrome flips nothing
    always_comb
    begin
        for (int p = 1; p <= code_w; p++)
        begin
            corrected[code_w - p] = code[code_w - p] ^ (syndrome == 4'(p));
        end
    end

    // skip powers of two, shift data in msb first
    always_comb
    begin
        data = '0;
        for (int p = 1; p <= code_w; p++)
        begin
            if ((p & (p - 1)) != 0)
            begin
                data = {data[data_w-2:0], corrected[code_w - p]};
            end
        end
    end

endmodule

// ==== hw/matrix_store.sv ====
// ============================================================
// decoded element registers and latched matrix size
// ============================================================
`timescale 1ns/100ps

module matrix_store
(
    input  logic                                               clk,
    input  logic                                               rst_n,
    input  logic                                               in_valid,
    input  logic [mdc_pkg::beat_w-1:0]                         beat,
    input  logic [mdc_pkg::mode_w-1:0]                         mode_dec,
    input  logic [mdc_pkg::elem_w-1:0]                         elem_dec,
    output logic [mdc_pkg::num_elems-1:0][mdc_pkg::elem_w-1:0] elems,
    output mdc_pkg::mat_size_e                                 mat_size
);
    import mdc_pkg::*;

    // ============================================================
    // element capture
    // ============================================================
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            elems <= '0;
        end
        else if (in_valid)
        begin
            elems[beat] <= elem_dec;
        end
    end

    // ============================================================
    // mode capture
    // ============================================================
    // only the first beat carries a mode word
    // anything but the size-3 code means size 2
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            mat_size <= SIZE2;
        end
        else if (in_valid && (beat == '0))
        begin
            if (mode_dec == mode_size3_code)
            begin
                mat_size <= SIZE3;
            end
            else
            begin
                mat_size <= SIZE2;
            end
        end
    end

endmodule

// ==== hw/mdc_ctrl.sv ====
// ============================================================
// control FSM for the collect, finish and output phases
// ============================================================
`timescale 1ns/100ps

module mdc_ctrl
(
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       in_valid,
    input  logic [mdc_pkg::beat_w-1:0] beat,
    output mdc_pkg::mdc_state_e        state,
    output logic                       next_is_idle,
    output logic                       out_valid
);
    import mdc_pkg::*;

    mdc_state_e next_state;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state     <= IDLE;
            out_valid <= 1'b0;
        end
        else
        begin
            state     <= next_state;
            out_valid <= (next_state == OUT);
        end
    end

    // the last beat of a matrix always arrives in CAL
    always_comb
    begin
        case (state)
            IDLE:    next_state = in_valid ? CAL : IDLE;
            CAL:     next_state = (beat == 4'd15) ? WAIT : CAL;
            WAIT:    next_state = OUT;
            default: next_state = IDLE;
        endcase
    end

    assign next_is_idle = (next_state == IDLE);

    // one result pulse per matrix, two cycles after its last beat
    a_single_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        (in_valid && beat == 4'd15) |-> ##2 out_valid ##1 !out_valid);

endmodule

// ==== hw/mdc_pkg.sv ====
// ============================================================
// shared widths, mode codes and types for the determinant
// calculator
// ============================================================

package mdc_pkg;

    // ============================================================
    // element and mode widths
    // ============================================================
    localparam int elem_w      = 11;
    localparam int elem_code_w = 15;
    localparam int mode_w      = 5;
    localparam int mode_code_w = 9;

    // one matrix is sixteen elements, row-major
    localparam int num_elems = 16;
    localparam int beat_w    = 4;

    // ============================================================
    // determinant and output layout
    // ============================================================
    localparam int det2_w  = 23;
    localparam int det3_w  = 36;
    localparam int slot2_w = 23;
    localparam int slot3_w = 51;
    // nine size-2 slots fill the bus exactly
    localparam int out_w   = 207;

    // decoded mode words
    localparam logic [mode_w-1:0] mode_size2_code = 5'b00100;
    localparam logic [mode_w-1:0] mode_size3_code = 5'b00110;

    // ============================================================
    // types
    // ============================================================
    typedef enum logic [1:0]
    {
        IDLE,
        CAL,
        WAIT,
        OUT
    } mdc_state_e;

    typedef enum logic
    {
        SIZE2,
        SIZE3
    } mat_size_e;

endpackage

// ==== hw/mdc_top.sv ====
// ============================================================
// matrix determinant calculator, top level
// hamming decode, element store, determinants, result bus
// ============================================================
`timescale 1ns/100ps

module mdc_top
(
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            in_valid,
    input  logic [mdc_pkg::mode_code_w-1:0] in_mode,
    input  logic [mdc_pkg::elem_code_w-1:0] in_data,
    output logic                            out_valid,
    output logic [mdc_pkg::out_w-1:0]       out_data
);
    import mdc_pkg::*;

    logic [mode_w-1:0]                mode_dec;
    logic [elem_w-1:0]                elem_dec;
    logic [beat_w-1:0]                beat;
    mdc_state_e                       state;
    logic                             next_is_idle;
    logic [num_elems-1:0][elem_w-1:0] elems;
    mat_size_e                        mat_size;
    logic signed [slot3_w-1:0]        det_value;
    logic                             slot_write;
    logic [3:0]                       slot_index;

    // ============================================================
    // input decode
    // ============================================================
    hamming_decoder #(.data_w(mode_w)) u_mode_dec (.code(in_mode), .data(mode_dec));

    hamming_decoder #(.data_w(elem_w)) u_elem_dec (.code(in_data), .data(elem_dec));

    // ============================================================
    // control
    // ============================================================
    beat_counter u_beat_counter (.clk(clk), .rst_n(rst_n), .in_valid(in_valid), .beat(beat));

    mdc_ctrl u_ctrl (.clk(clk), .rst_n(rst_n), .in_valid(in_valid), .beat(beat),
                     .state(state), .next_is_idle(next_is_idle), .out_valid(out_valid));

    // ============================================================
    // datapath
    // ============================================================
    matrix_store u_store (.clk(clk), .rst_n(rst_n), .in_valid(in_valid), .beat(beat),
                          .mode_dec(mode_dec), .elem_dec(elem_dec),
                          .elems(elems), .mat_size(mat_size));

    det_unit u_det (.state(state), .beat(beat), .elems(elems), .mat_size(mat_size),
                    .det_value(det_value), .slot_write(slot_write),
                    .slot_index(slot_index));

    result_assembler u_result (.clk(clk), .rst_n(rst_n), .state(state),
                               .next_is_idle(next_is_idle), .mat_size(mat_size),
                               .det_value(det_value), .slot_write(slot_write),
                               .slot_index(slot_index), .out_data(out_data));

endmodule

// ==== hw/result_assembler.sv ====
// ============================================================
// result register, slot writes and gated output bus
// ============================================================
`timescale 1ns/100ps

module result_assembler
(
    input  logic                               clk,
    input  logic                               rst_n,
    input  mdc_pkg::mdc_state_e                state,
    input  logic                               next_is_idle,
    input  mdc_pkg::mat_size_e                 mat_size,
    input  logic signed [mdc_pkg::slot3_w-1:0] det_value,
    input  logic                               slot_write,
    input  logic [3:0]                         slot_index,
    output logic [mdc_pkg::out_w-1:0]          out_data
);
    import mdc_pkg::*;

    logic [out_w-1:0] result_reg;

    // ============================================================
    // slot writes
    // ============================================================
    // size 2: nine 23-bit slots from bit 206 down
    // size 3: four 51-bit slots from bit 203 down, top 3 bits stay 0
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            result_reg <= '0;
        end
        else if (next_is_idle)
        begin
            result_reg <= '0;
        end
        else if (slot_write)
        begin
            if (mat_size == SIZE2)
            begin
                result_reg[out_w - 1 - slot2_w * slot_index -: slot2_w]
                    <= det_value[slot2_w-1:0];
            end
            else
            begin
                result_reg[4 * slot3_w - 1 - slot3_w * slot_index[1:0] -: slot3_w]
                    <= det_value;
            end
        end
    end

    // ============================================================
    // output
    // ============================================================
    always_comb
    begin
        if (state == OUT)
        begin
            out_data = result_reg;
        end
        else
        begin
            out_data = '0;
        end
    end

endmodule

// ==== run.sh ====
#!/bin/sh
# build the determinant calculator testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_mdc -f compile.f \
    -Mdir obj_dir > build.log 2>&1 \
    || { echo "build failed, see build.log"; exit 1; }

./obj_dir/Vtb_mdc > sim.log 2>&1

grep -qF "*** TEST PASSED ***" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }

// ==== testbench/mdc_checker.sv ====
// ============================================================
// reference model and output checks for the determinant
// calculator
// expected results come from the clean matrix
// ============================================================
`timescale 1ns/100ps

module mdc_checker
(
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          in_valid,
    input  logic [mdc_pkg::mode_w-1:0]    clean_mode,
    input  logic [mdc_pkg::elem_w-1:0]    clean_elem,
    input  logic                          out_valid,
    input  logic [mdc_pkg::out_w-1:0]     out_data,
    output int                            value_errors,
    output int                            timing_errors,
    output int                            results_seen,
    output int                            pending
);
    import mdc_pkg::*;

    logic [elem_w-1:0] mat [num_elems];
    logic [mode_w-1:0] mode_reg;
    logic [out_w-1:0]  exp_data [$];
    int                due_cycle [$];
    int                cnt;
    int                cyc;
    logic              exp_valid;

    // ============================================================
    // reference determinants over sliding windows
    // ============================================================
    function automatic logic [out_w-1:0] expected_result(input logic [mode_w-1:0] mode_val);
        logic [out_w-1:0] res;
        longint           a [3][3];
        longint           d;
        int               base;
        res = '0;
        if (mode_val == mode_size3_code)
        begin
            for (int w = 0; w < 4; w++)
            begin
                base = 4 * (w / 2) + (w % 2);
                for (int r = 0; r < 3; r++)
                begin
                    for (int c = 0; c < 3; c++)
                    begin
                        a[r][c] = $signed(mat[base + 4 * r + c]);
                    end
                end
                // expansion along the top row
                d = a[0][0] * (a[1][1] * a[2][2] - a[1][2] * a[2][1])
                  - a[0][1] * (a[1][0] * a[2][2] - a[1][2] * a[2][0])
                  + a[0][2] * (a[1][0] * a[2][1] - a[1][1] * a[2][0]);
                res[203 - 51 * w -: 51] = d[50:0];
            end
        end
        else
        begin
            for (int w = 0; w < 9; w++)
            begin
                base = 4 * (w / 3) + (w % 3);
                for (int r = 0; r < 2; r++)
                begin
                    for (int c = 0; c < 2; c++)
                    begin
                        a[r][c] = $signed(mat[base + 4 * r + c]);
                    end
                end
                d = a[0][0] * a[1][1] - a[0][1] * a[1][0];
                res[206 - 23 * w -: 23] = d[22:0];
            end
        end
        return res;
    endfunction

    // ============================================================
    // checks on the falling edge
    // ============================================================
    always @(negedge clk)
    begin
        if (!rst_n)
        begin
            cnt           = 0;
            cyc           = 0;
            value_errors  = 0;
            timing_errors = 0;
            results_seen  = 0;
            pending       = 0;
        end
        else
        begin
            cyc++;
            exp_valid = (due_cycle.size() > 0) && (due_cycle[0] == cyc);
            // result pulses from the DUT
            if (out_valid === 1'b1)
            begin
                results_seen++;
            end
            if (out_valid !== exp_valid)
            begin
                timing_errors++;
                $display("CHECK FAILED out_valid expected %h got %h at %0t",
                         exp_valid, out_valid, $time);
            end
            if (exp_valid)
            begin
                if (out_data !== exp_data[0])
                begin
                    value_errors++;
                    $display("CHECK FAILED out_data expected %h got %h at %0t",
                             exp_data[0], out_data, $time);
                end
                void'(exp_data.pop_front());
                void'(due_cycle.pop_front());
            end
            else if (out_data !== '0)
            begin
                value_errors++;
                $display("CHECK FAILED out_data expected %h got %h at %0t",
                         {out_w{1'b0}}, out_data, $time);
            end
            // own copy of the matrix
            // result due two cycles after the last beat
            if (in_valid)
            begin
                if (cnt == 0)
                begin
                    mode_reg = clean_mode;
                end
                mat[cnt] = clean_elem;
                if (cnt == num_elems - 1)
                begin
                    exp_data.push_back(expected_result(mode_reg));
                    due_cycle.push_back(cyc + 2);
                end
                cnt = (cnt + 1) % num_elems;
            end
            pending = due_cycle.size();
        end
    end

endmodule

// ==== testbench/tb_clock_gen.sv ====
// ============================================================
// testbench clock and reset source
// ============================================================
`timescale 1ns/100ps

module tb_clock_gen #(
    parameter int period_ns    = 40,
    parameter int reset_cycles = 4
)
(
    output logic clk,
    output logic rst_n
);

    initial
    begin
        clk = 1'b0;
        forever #(period_ns / 2) clk = ~clk;
    end

    // release just after an edge, like the other inputs
    initial
    begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        #5;
        rst_n = 1'b1;
    end

endmodule

// ==== testbench/tb_mdc.sv ====
// ============================================================
// testbench top with random coded matrices, single-bit
// errors, a watchdog and the final verdict
// ============================================================
`timescale 1ns/100ps

module tb_mdc;
    import mdc_pkg::*;

    localparam int num_tests     = 40;
    localparam int clk_period_ns = 40;
    localparam int watchdog_ns   = num_tests * 24 * clk_period_ns * 2;

    logic                   clk;
    logic                   rst_n;
    logic                   in_valid;
    logic [mode_code_w-1:0] in_mode;
    logic [elem_code_w-1:0] in_data;
    logic                   out_valid;
    logic [out_w-1:0]       out_data;
    logic [mode_w-1:0]      clean_mode;
    logic [elem_w-1:0]      clean_elem;
    logic [15:0]            lfsr;
    logic [31:0]            gap_bits;
    int                     value_errors;
    int                     timing_errors;
    int                     results_seen;
    int                     pending;

    tb_clock_gen #(.period_ns(clk_period_ns), .reset_cycles(4)) u_clk (.clk(clk), .rst_n(rst_n));

    mdc_top dut0 (.clk(clk), .rst_n(rst_n), .in_valid(in_valid), .in_mode(in_mode),
                  .in_data(in_data), .out_valid(out_valid), .out_data(out_data));

    mdc_checker u_checker (.clk(clk), .rst_n(rst_n), .in_valid(in_valid),
                           .clean_mode(clean_mode), .clean_elem(clean_elem),
                           .out_valid(out_valid), .out_data(out_data),
                           .value_errors(value_errors), .timing_errors(timing_errors),
                           .results_seen(results_seen), .pending(pending));

    // ============================================================
    // random source and hamming encoder
    // ============================================================
    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bits(input int count, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < count; i++)
        begin
            lfsr = lfsr_step(lfsr);
            value = {value[30:0], lfsr[0]};
        end
    endtask

    // position p sits at bit n-p
    // parity bits make every syndrome bit even
    function automatic logic [14:0] hamming_encode(input logic [10:0] value, input int data_w);
        logic [14:0] code;
        logic [3:0]  syn;
        int          n;
        int          k;
        n = data_w + 4;
        code = '0;
        syn = '0;
        k = data_w - 1;
        for (int p = 1; p <= n; p++)
        begin
            if ((p & (p - 1)) != 0)
            begin
                if (value[k])
                begin
                    code[n - p] = 1'b1;
                    syn = syn ^ 4'(p);
                end
                k--;
            end
        end
        for (int j = 0; j < 4; j++)
        begin
            if (syn[j])
            begin
                code[n - (1 << j)] = 1'b1;
            end
        end
        return code;
    endfunction

    // half the words get one flipped bit
    task automatic flip_random_bit(input int n, inout logic [14:0] code);
        logic [31:0] r;
        take_bits(1, r);
        if (r[0])
        begin
            take_bits(4, r);
            code[r % n] = ~code[r % n];
        end
    endtask

    // ============================================================
    // one matrix as sixteen back-to-back beats
    // ============================================================
    task automatic send_matrix(input int t);
        logic [31:0]       r;
        logic [mode_w-1:0] mode;
        logic [elem_w-1:0] elem;
        logic [14:0]       code;
        logic              extreme;
        take_bits(2, r);
        case (r[1:0])
            2'd0:    mode = mode_size2_code;
            2'd1:
            begin
                take_bits(mode_w, r);
                mode = r[mode_w-1:0];
            end
            default: mode = mode_size3_code;
        endcase
        // every fifth matrix uses only the most negative and most positive values
        extreme = (t % 5 == 4);
        for (int k = 0; k < num_elems; k++)
        begin
            take_bits(extreme ? 1 : elem_w, r);
            elem = extreme ? (r[0] ? 11'h3ff : 11'h400) : r[elem_w-1:0];
            code = hamming_encode(elem, elem_w);
            flip_random_bit(elem_code_w, code);
            @(posedge clk);
            #5;
            in_valid = 1'b1;
            clean_elem = elem;
            in_data = code;
            in_mode = '0;
            if (k == 0)
            begin
                code = hamming_encode({6'd0, mode}, mode_w);
                flip_random_bit(mode_code_w, code);
                clean_mode = mode;
                in_mode = code[mode_code_w-1:0];
            end
        end
    endtask

    initial
    begin
        in_valid   = 1'b0;
        in_mode    = '0;
        in_data    = '0;
        clean_mode = '0;
        clean_elem = '0;
        lfsr       = 16'd50;
        @(posedge rst_n);
        for (int t = 0; t < num_tests; t++)
        begin
            send_matrix(t);
            take_bits(2, gap_bits);
            repeat (gap_bits[1:0] + 1)
            begin
                @(posedge clk);
                #5;
                in_valid = 1'b0;
            end
        end
        wait (results_seen == num_tests);
        repeat (3) @(posedge clk);
        $display("value errors %0d, timing errors %0d, results %0d of %0d, pending %0d",
                 value_errors, timing_errors, results_seen, num_tests, pending);
        if (value_errors == 0 && timing_errors == 0 && results_seen == num_tests
            && pending == 0)
        begin
            $display("*** TEST PASSED ***");
        end
        else
        begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    // ============================================================
    // watchdog at twice the estimated run length
    // ============================================================
    initial
    begin
        #(watchdog_ns);
        $display("watchdog expired after %0d ns with %0d results seen",
                 watchdog_ns, results_seen);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule
